/* files.f */
+incdir+logic
logic/flash_cache_pkg.sv
logic/line_fill_if.sv
logic/cache_port_if.sv
logic/line_cache.sv
logic/ahb_cache_ctrl.sv
logic/qspi_line_reader.sv
logic/ahb_flash_ctrl.sv
dv/qspi_flash_model.sv
dv/tb_ahb_flash_ctrl.sv

/* run.sh */
#!/bin/sh
# Build and run the AHB flash controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_ahb_flash_ctrl \
    -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx '=== PASS ==='; then
    exit 0
fi
exit 1

/* dv/tb_ahb_flash_ctrl.sv */
`timescale 1ns/1ps
`include "flash_cache_settings.svh"

module tb_ahb_flash_ctrl;
    import flash_cache_pkg::*;

    localparam int unsigned addr_bits    = `FC_FLASH_ADDR_BITS;
    localparam int unsigned offset_bits  = $clog2(`FC_LINE_BITS / 8);
    localparam int unsigned index_bits   = $clog2(`FC_NUM_LINES);
    localparam int unsigned tag_bits     = addr_bits - offset_bits - index_bits;
    localparam int unsigned wait_limit   = 400;
    localparam int unsigned random_reads = 200;
    localparam int unsigned num_entries  = 12;

    typedef struct packed {
        logic [31:0] addr;
        logic        miss;
        logic        write;
    } entry_t;

    // 0x100, 0x300 and 0x500 all share index 16
    entry_t directed [num_entries] = '{
        '{32'h0000_0104, 1'b1, 1'b0},
        '{32'h0000_0100, 1'b0, 1'b0},
        '{32'h0000_0108, 1'b0, 1'b0},
        '{32'h0000_010c, 1'b0, 1'b0},
        '{32'h0000_0500, 1'b0, 1'b1},
        '{32'h0000_0300, 1'b1, 1'b0},
        '{32'h0000_0304, 1'b0, 1'b0},
        '{32'h0000_0100, 1'b1, 1'b0},
        '{32'h0000_0110, 1'b1, 1'b0},
        '{32'h00ab_cde8, 1'b1, 1'b0},
        '{32'h00ab_cde0, 1'b0, 1'b0},
        '{32'h0000_0500, 1'b1, 1'b0}
    };

    logic      clk = 1'b0;
    logic      rst_n;
    logic      hsel;
    ahb_addr_t haddr;
    htrans_t   htrans;
    logic      hwrite;
    logic      hready;
    logic      hreadyout;
    word_t     hrdata;
    logic      sck;
    logic      ce_n;
    logic      douten;
    nibble_t   din;
    nibble_t   dout;

    int unsigned         error_count;
    int unsigned         timeout_count;
    logic                timed_out;
    logic                first_fetch_done;
    integer              seed;
    logic                mirror_valid [`FC_NUM_LINES];
    logic [tag_bits-1:0] mirror_tag   [`FC_NUM_LINES];

    always #2 clk = ~clk;

    // Single slave on the bus
    assign hready = hreadyout;

    ahb_flash_ctrl i_ahb_flash_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .hsel      (hsel),
        .haddr     (haddr),
        .htrans    (htrans),
        .hwrite    (hwrite),
        .hready    (hready),
        .hreadyout (hreadyout),
        .hrdata    (hrdata),
        .sck       (sck),
        .ce_n      (ce_n),
        .din       (din),
        .dout      (dout),
        .douten    (douten)
    );

    qspi_flash_model i_qspi_flash_model (
        .ce_n (ce_n),
        .sck  (sck),
        .dout (dout),
        .din  (din)
    );

    function automatic logic [7:0] flash_byte(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ 8'h5a;
    endfunction

    // Little-endian word at the word-aligned address
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [23:0] base;
        logic [31:0] word;
        base = {addr[23:2], 2'b00};
        for (int k = 0; k < 4; k++) begin
            word[8*k +: 8] = flash_byte(base + 24'(k));
        end
        return word;
    endfunction

    function automatic logic predict_miss(input logic [31:0] addr);
        logic [index_bits-1:0] idx;
        logic [tag_bits-1:0]   tag;
        idx = addr[offset_bits +: index_bits];
        tag = addr[addr_bits-1 -: tag_bits];
        return ~(mirror_valid[idx] & (mirror_tag[idx] == tag));
    endfunction

    task automatic record_fill(input logic [31:0] addr);
        logic [index_bits-1:0] idx;
        idx                = addr[offset_bits +: index_bits];
        mirror_valid[idx] = 1'b1;
        mirror_tag[idx]   = addr[addr_bits-1 -: tag_bits];
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_cond(input logic ok, input string msg);
        assert (ok) else begin
            $display("%s", msg);
            error_count++;
        end
    endtask

    // One non-pipelined transfer, then checks on data, wait states and flash traffic
    task automatic apply_transfer(input logic [31:0] addr, input logic is_write,
                                  input logic expect_miss);
        int unsigned waits;
        int unsigned trans_before;
        logic [31:0] got;
        trans_before = i_qspi_flash_model.trans_count;
        @(posedge clk);
        #0.5;
        hsel   = 1'b1;
        haddr  = addr;
        htrans = 2'b10;
        hwrite = is_write;
        @(posedge clk);
        #0.5;
        hsel   = 1'b0;
        haddr  = '0;
        htrans = 2'b00;
        hwrite = 1'b0;
        waits  = 0;
        while (hreadyout !== 1'b1 && waits < wait_limit) begin
            @(posedge clk);
            #0.5;
            waits++;
        end
        if (hreadyout !== 1'b1) begin
            $display("Timeout: hreadyout still low %0d cycles after access to 0x%h",
                     waits, addr);
            timeout_count++;
            timed_out = 1'b1;
            return;
        end
        got = hrdata;
        if (is_write) begin
            check_cond(waits == 0, $sformatf("Write to 0x%h took %0d wait states",
                                             addr, waits));
            check_cond(i_qspi_flash_model.trans_count == trans_before,
                       $sformatf("Write to 0x%h started a flash transfer", addr));
            return;
        end
        check_equal($sformatf("hrdata at 0x%h", addr), got, expected_word(addr));
        if (expect_miss) begin
            check_cond(waits > 0, $sformatf("Read at 0x%h should miss but had no wait states",
                                            addr));
            check_cond(i_qspi_flash_model.trans_count == trans_before + 1,
                       $sformatf("Miss at 0x%h did not run exactly one flash transfer", addr));
            check_equal("flash address", {8'h00, i_qspi_flash_model.rx_addr},
                        {8'h00, addr[23:4], 4'h0});
            check_equal("flash mode byte", {24'h0, i_qspi_flash_model.rx_mode},
                        {24'h0, `FC_MODE_BYTE});
            if (!first_fetch_done) begin
                check_equal("flash opcode", {24'h0, i_qspi_flash_model.rx_opcode},
                            {24'h0, `FC_READ_CMD});
            end else begin
                check_cond(~i_qspi_flash_model.had_opcode,
                           $sformatf("Flash transfer for 0x%h sent an opcode again", addr));
            end
            first_fetch_done = 1'b1;
            record_fill(addr);
        end else begin
            check_cond(waits == 0, $sformatf("Read at 0x%h should hit but took %0d wait states",
                                             addr, waits));
            check_cond(i_qspi_flash_model.trans_count == trans_before,
                       $sformatf("Hit at 0x%h selected the flash", addr));
        end
    endtask

    initial begin
        int unsigned reads;
        logic [31:0] rnd;
        logic [31:0] addr;
        logic        is_write;
        rst_n            = 1'b0;
        hsel             = 1'b0;
        haddr            = '0;
        htrans           = 2'b00;
        hwrite           = 1'b0;
        error_count      = 0;
        timeout_count    = 0;
        timed_out        = 1'b0;
        first_fetch_done = 1'b0;
        seed             = 32'hb1fd_9af2;
        for (int i = 0; i < `FC_NUM_LINES; i++) begin
            mirror_valid[i] = 1'b0;
            mirror_tag[i]   = '0;
        end

        repeat (8) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        check_equal("hreadyout", {31'b0, hreadyout}, 32'h1);
        check_equal("ce_n", {31'b0, ce_n}, 32'h1);
        check_equal("sck", {31'b0, sck}, 32'h0);
        check_equal("douten", {31'b0, douten}, 32'h0);

        for (int i = 0; i < num_entries && !timed_out; i++) begin
            apply_transfer(directed[i].addr, directed[i].write, directed[i].miss);
        end

        // Random reads in a 4 KB window with writes mixed in
        reads = 0;
        while (reads < random_reads && !timed_out) begin
            rnd      = $random(seed);
            addr     = {20'h0, rnd[11:2], 2'b00};
            is_write = (rnd[31:29] == 3'b000);
            apply_transfer(addr, is_write, predict_miss(addr));
            if (!is_write) begin
                reads++;
            end
        end

        $display("errors: %0d check, %0d timeout", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* dv/qspi_flash_model.sv */
`timescale 1ns/1ps
`include "flash_cache_settings.svh"

module qspi_flash_model (
    input  logic                     ce_n,
    input  logic                     sck,
    input  flash_cache_pkg::nibble_t dout,
    output flash_cache_pkg::nibble_t din
);
    import flash_cache_pkg::*;

    localparam int unsigned data_start = `FC_DATA_START;
    localparam int unsigned data_end   = `FC_DATA_START + `FC_LINE_NIBBLES;

    // What the last transaction carried, read by the testbench
    int unsigned trans_count;
    logic        had_opcode;
    logic [7:0]  rx_opcode;
    logic [23:0] rx_addr;
    logic [7:0]  rx_mode;

    logic        cont_mode;
    int unsigned step;
    int unsigned nib;
    line_t       line_data;
    logic [7:0]  cur_byte;

    initial begin
        din         = '0;
        trans_count = 0;
        cont_mode   = 1'b0;
        forever begin
            @(negedge ce_n);
            trans_count++;
            // Continuous mode skips the opcode and starts at the address
            had_opcode = ~cont_mode;
            step       = cont_mode ? 8 : 0;
            rx_opcode  = '0;
            rx_addr    = '0;
            rx_mode    = '0;
            while (!ce_n) begin
                @(posedge sck or posedge ce_n);
                if (!ce_n) begin
                    if (step < 8) begin
                        rx_opcode = {rx_opcode[6:0], dout[0]};
                    end else if (step < 14) begin
                        rx_addr = {rx_addr[19:0], dout};
                    end else if (step < 16) begin
                        rx_mode = {rx_mode[3:0], dout};
                    end
                    if (step == 13) begin
                        for (int k = 0; k < 16; k++) begin
                            cur_byte = 8'(rx_addr + 24'(k)) ^ 8'((rx_addr + 24'(k)) >> 8)
                                       ^ 8'h5a;
                            line_data[8*k +: 8] = cur_byte;
                        end
                    end
                    if (step == 15) begin
                        cont_mode = (rx_mode[7:4] == 4'ha);
                    end
                    step++;
                    // Next nibble goes out shortly after sck falls
                    @(negedge sck);
                    if (step >= data_start && step < data_end) begin
                        nib      = step - data_start;
                        cur_byte = line_data[(nib / 2) * 8 +: 8];
                        #1;
                        din = (nib % 2 == 1) ? cur_byte[3:0] : cur_byte[7:4];
                    end
                end
            end
        end
    end

endmodule

/* logic/ahb_flash_ctrl.sv */
`timescale 1ns/1ps
`include "flash_cache_settings.svh"

module ahb_flash_ctrl #(
    parameter int unsigned num_lines = `FC_NUM_LINES
) (
    input  logic                       clk,
    input  logic                       rst_n,

    // AHB-Lite slave, read only
    input  logic                       hsel,
    input  flash_cache_pkg::ahb_addr_t haddr,
    input  flash_cache_pkg::htrans_t   htrans,
    input  logic                       hwrite,
    input  logic                       hready,
    output logic                       hreadyout,
    output flash_cache_pkg::word_t     hrdata,

    // Quad I/O flash pins
    output logic                       sck,
    output logic                       ce_n,
    input  flash_cache_pkg::nibble_t   din,
    output flash_cache_pkg::nibble_t   dout,
    output logic                       douten
);

    line_fill_if fill ();

    ahb_cache_ctrl #(
        .num_lines (num_lines)
    ) i_ahb_cache_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .hsel      (hsel),
        .haddr     (haddr),
        .htrans    (htrans),
        .hwrite    (hwrite),
        .hready    (hready),
        .hreadyout (hreadyout),
        .hrdata    (hrdata),
        .fill      (fill.requester)
    );

    qspi_line_reader i_qspi_line_reader (
        .clk    (clk),
        .rst_n  (rst_n),
        .fill   (fill.reader),
        .sck    (sck),
        .ce_n   (ce_n),
        .din    (din),
        .dout   (dout),
        .douten (douten)
    );

endmodule

/* logic/qspi_line_reader.sv */
`timescale 1ns/1ps
`include "flash_cache_settings.svh"

module qspi_line_reader (
    input  logic                     clk,
    input  logic                     rst_n,
    line_fill_if.reader              fill,
    output logic                     sck,
    output logic                     ce_n,
    input  flash_cache_pkg::nibble_t din,
    output flash_cache_pkg::nibble_t dout,
    output logic                     douten
);
    import flash_cache_pkg::*;

    localparam int unsigned line_bytes = $bits(line_t) / 8;
    localparam int unsigned byte_bits  = $clog2(line_bytes);
    localparam int unsigned last_step  = `FC_DATA_START + `FC_LINE_NIBBLES;
    localparam int unsigned step_bits  = $clog2(last_step + 1);

    localparam logic [step_bits-1:0] data_first = step_bits'(`FC_DATA_START);
    localparam logic [step_bits-1:0] done_step  = step_bits'(last_step);
    // Continuous-read transfers open directly with the address
    localparam logic [step_bits-1:0] cont_start = step_bits'(8);

    localparam logic [7:0] read_cmd  = `FC_READ_CMD;
    localparam logic [7:0] mode_byte = `FC_MODE_BYTE;

    reader_state_t               state;
    logic [step_bits-1:0]        step;
    logic [step_bits-1:0]        data_step;
    logic [byte_bits-1:0]        byte_idx;
    logic                        cont_mode;
    logic                        start;
    logic                        in_data;
    flash_addr_t                 addr_q;
    logic [line_bytes-1:0][7:0]  line_q;

    assign start     = (state == reader_idle) & fill.rd;
    assign fill.done = (state == reader_read) & (step == done_step);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= reader_idle;
        end else if (start) begin
            state <= reader_read;
        end else if (fill.done) begin
            state <= reader_idle;
        end
    end

    // Set after the first complete transfer, flash then stays in continuous read
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cont_mode <= 1'b0;
        end else if (fill.done) begin
            cont_mode <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ce_n <= 1'b1;
        end else if (start) begin
            ce_n <= 1'b0;
        end else if (fill.done) begin
            ce_n <= 1'b1;
        end
    end

    // Two clocks per step, low half then high half
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sck <= 1'b0;
        end else if (ce_n || fill.done) begin
            sck <= 1'b0;
        end else begin
            sck <= ~sck;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step <= '0;
        end else if (state == reader_idle) begin
            step <= cont_mode ? cont_start : '0;
        end else if (sck) begin
            step <= step + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= fill.addr;
        end
    end

    // High nibble of each byte arrives first
    assign in_data   = (state == reader_read) & sck & (step >= data_first) & (step < done_step);
    assign data_step = step - data_first;
    assign byte_idx  = data_step[byte_bits:1];

    always_ff @(posedge clk) begin
        if (in_data) begin
            line_q[byte_idx] <= {line_q[byte_idx][3:0], din};
        end
    end

    assign fill.line = line_q;

    always_comb begin
        dout = '0;
        if (step < cont_start) begin
            // Opcode goes out serially on bit 0, MSB first
            dout = {3'b000, read_cmd[~step[2:0]]};
        end else begin
            case (step)
                8:       dout = addr_q[20 +: 4];
                9:       dout = addr_q[16 +: 4];
                10:      dout = addr_q[12 +: 4];
                11:      dout = addr_q[8 +: 4];
                12:      dout = addr_q[4 +: 4];
                13:      dout = addr_q[0 +: 4];
                14:      dout = mode_byte[7:4];
                15:      dout = mode_byte[3:0];
                default: dout = '0;
            endcase
        end
    end

    // Drive the pins only up to the end of the dummy nibbles
    assign douten = ~ce_n & (step < data_first);

endmodule

/* logic/ahb_cache_ctrl.sv */
`timescale 1ns/1ps
`include "flash_cache_settings.svh"

module ahb_cache_ctrl #(
    parameter int unsigned num_lines = `FC_NUM_LINES
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       hsel,
    input  flash_cache_pkg::ahb_addr_t haddr,
    input  flash_cache_pkg::htrans_t   htrans,
    input  logic                       hwrite,
    input  logic                       hready,
    output logic                       hreadyout,
    output flash_cache_pkg::word_t     hrdata,
    line_fill_if.requester             fill
);
    import flash_cache_pkg::*;

    localparam int unsigned addr_bits   = $bits(flash_addr_t);
    localparam int unsigned offset_bits = $clog2($bits(line_t) / 8);

    ctrl_state_t state;
    flash_addr_t haddr_q;
    logic        read_req;
    logic        miss;
    logic        fill_en;

    cache_port_if port ();

    line_cache #(
        .num_lines (num_lines)
    ) i_line_cache (
        .clk   (clk),
        .rst_n (rst_n),
        .port  (port.cache)
    );

    // Accepted read: selected, not a write, NONSEQ or SEQ
    assign read_req = hsel & hready & ~hwrite & htrans[1];
    assign miss     = read_req & ~port.hit;

    // Data phase address follows the bus only when the transfer is accepted
    always_ff @(posedge clk) begin
        if (hready) begin
            haddr_q <= haddr[addr_bits-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ctrl_idle;
            hreadyout <= 1'b1;
        end else begin
            case (state)
                ctrl_wait_fill: begin
                    // Line lands in the cache on this edge
                    if (fill_en) begin
                        state     <= ctrl_serve;
                        hreadyout <= 1'b1;
                    end
                end
                default: begin
                    if (miss) begin
                        state     <= ctrl_wait_fill;
                        hreadyout <= 1'b0;
                    end else if (read_req) begin
                        state     <= ctrl_serve;
                        hreadyout <= 1'b1;
                    end else begin
                        state     <= ctrl_idle;
                        hreadyout <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Cache write one cycle after the reader finishes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fill_en <= 1'b0;
        end else begin
            fill_en <= fill.done;
        end
    end

    // Miss request goes out during the address phase itself
    assign fill.rd   = miss & (state != ctrl_wait_fill);
    assign fill.addr = {haddr[addr_bits-1:offset_bits], {offset_bits{1'b0}}};

    assign port.lookup_addr = haddr[addr_bits-1:0];
    assign port.data_addr   = haddr_q;
    assign port.fill_en     = fill_en;
    assign port.fill_line   = fill.line;

    assign hrdata = port.rdata;

endmodule

/* logic/line_cache.sv */
`timescale 1ns/1ps
`include "flash_cache_settings.svh"

module line_cache #(
    parameter int unsigned num_lines = `FC_NUM_LINES
) (
    input  logic       clk,
    input  logic       rst_n,
    cache_port_if.cache port
);
    import flash_cache_pkg::*;

    localparam int unsigned addr_bits   = $bits(flash_addr_t);
    localparam int unsigned offset_bits = $clog2($bits(line_t) / 8);
    localparam int unsigned index_bits  = $clog2(num_lines);
    localparam int unsigned tag_bits    = addr_bits - offset_bits - index_bits;
    localparam int unsigned word_lsb    = $clog2($bits(word_t) / 8);
    localparam int unsigned word_bits   = offset_bits - word_lsb;

    logic [num_lines-1:0] valid;
    logic [tag_bits-1:0]  tags  [num_lines];
    line_t                lines [num_lines];

    logic [index_bits-1:0] lookup_index;
    logic [tag_bits-1:0]   lookup_tag;
    logic [index_bits-1:0] data_index;
    logic [tag_bits-1:0]   data_tag;
    logic [word_bits-1:0]  word_sel;
    line_t                 sel_line;

    // Address split: tag | index | byte offset
    assign lookup_index = port.lookup_addr[offset_bits +: index_bits];
    assign lookup_tag   = port.lookup_addr[addr_bits-1 -: tag_bits];
    assign data_index   = port.data_addr[offset_bits +: index_bits];
    assign data_tag     = port.data_addr[addr_bits-1 -: tag_bits];
    assign word_sel     = port.data_addr[word_lsb +: word_bits];

    assign port.hit = valid[lookup_index] & (tags[lookup_index] == lookup_tag);

    assign sel_line   = lines[data_index];
    assign port.rdata = sel_line[word_sel * $bits(word_t) +: $bits(word_t)];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (port.fill_en) begin
            valid[data_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (port.fill_en) begin
            tags[data_index]  <= data_tag;
            lines[data_index] <= port.fill_line;
        end
    end

endmodule

/* logic/cache_port_if.sv */
`timescale 1ns/1ps

interface cache_port_if;
    import flash_cache_pkg::*;

    // Address phase address, used for the hit check
    flash_addr_t lookup_addr;
    // Data phase address, used for word select and fills
    flash_addr_t data_addr;
    word_t       rdata;
    logic        hit;
    logic        fill_en;
    line_t       fill_line;

    modport ctrl (
        output lookup_addr,
        output data_addr,
        output fill_en,
        output fill_line,
        input  rdata,
        input  hit
    );

    modport cache (
        input  lookup_addr,
        input  data_addr,
        input  fill_en,
        input  fill_line,
        output rdata,
        output hit
    );
endinterface

/* logic/line_fill_if.sv */
`timescale 1ns/1ps

interface line_fill_if;
    import flash_cache_pkg::*;

    // Line-aligned flash address of the requested line
    flash_addr_t addr;
    logic        rd;
    logic        done;
    // Holds from done until the next rd
    line_t       line;

    modport requester (
        output addr,
        output rd,
        input  done,
        input  line
    );

    modport reader (
        input  addr,
        input  rd,
        output done,
        output line
    );
endinterface

/* logic/flash_cache_pkg.sv */
`include "flash_cache_settings.svh"

package flash_cache_pkg;

    // AHB side
    typedef logic [31:0] ahb_addr_t;
    typedef logic [31:0] word_t;
    typedef logic [1:0]  htrans_t;

    // Flash side
    typedef logic [`FC_FLASH_ADDR_BITS-1:0] flash_addr_t;
    typedef logic [3:0]                     nibble_t;

    // Byte 0 of the line sits in bits 7:0
    typedef logic [`FC_LINE_BITS-1:0] line_t;

    typedef enum logic [1:0] {
        ctrl_idle,
        ctrl_wait_fill,
        ctrl_serve
    } ctrl_state_t;

    typedef enum logic {
        reader_idle,
        reader_read
    } reader_state_t;

endpackage

/* logic/flash_cache_settings.svh */
`ifndef FLASH_CACHE_SETTINGS_SVH
`define FLASH_CACHE_SETTINGS_SVH

// Cache geometry
`define FC_LINE_BITS        128
`define FC_NUM_LINES        32

// Flash byte address width
`define FC_FLASH_ADDR_BITS  24

// Quad I/O fast read protocol
`define FC_READ_CMD         8'heb
`define FC_MODE_BYTE        8'ha5

// Step at which the flash starts returning data
`define FC_DATA_START       20
// Nibbles in one 128-bit line
`define FC_LINE_NIBBLES     32

`endif
